// ==== build.f ====
logic/core_ctrl_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/fwd_unit.sv
logic/core_ctrl.sv
dv/core_ctrl_tb.sv

// ==== dv/core_ctrl_tb.sv ====
`timescale 1ns/1ps

module core_ctrl_tb;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 5;
  localparam int REG_ADDR_W   = 6;
  localparam int IRQ_ID_W     = 5;

  // instruction kinds the table can place in id
  typedef enum logic [2:0] {
    OP_NOP,
    OP_ILL,
    OP_ECALL,
    OP_WFI,
    OP_JALR
  } op_e;

  // one cycle of stimulus followed by its expected outputs
  typedef struct packed {
    logic [2:0] grp;
    logic [8:0] ctl;
    op_e        op;
    logic [4:0] haz;
    logic [8:0] mat;
    logic [9:0] flags;
    logic [2:0] mux;
    logic [5:0] cause;
    logic [5:0] fw;
  } row_t;

  logic                       clk;
  logic                       rst_n;
  logic                       fetch_enable_i;
  logic                       instr_valid_i;
  logic                       id_ready_i;
  logic                       ex_valid_i;
  logic                       branch_taken_ex_i;
  logic                       irq_i;
  logic                       irq_req_i;
  logic [IRQ_ID_W-1:0]        irq_id_i;
  logic                       m_ie_i;
  logic                       u_ie_i;
  core_ctrl_pkg::priv_lvl_e   priv_lvl_i;
  core_ctrl_pkg::dec_info_t   dec_i;
  logic                       data_req_ex_i;
  logic                       regfile_we_id_i;
  logic                       regfile_we_ex_i;
  logic                       regfile_we_wb_i;
  logic                       regfile_alu_we_fw_i;
  logic                       wb_ready_i;
  logic [REG_ADDR_W-1:0]      waddr_id_i;
  logic [REG_ADDR_W-1:0]      waddr_ex_i;
  core_ctrl_pkg::reg_match_t  match_ex_i;
  core_ctrl_pkg::reg_match_t  match_wb_i;
  core_ctrl_pkg::reg_match_t  match_alu_i;
  logic                       data_misaligned_i;
  core_ctrl_pkg::pc_ctrl_t    pc_ctrl_o;
  core_ctrl_pkg::csr_ctrl_t   csr_ctrl_o;
  logic                       instr_req_o;
  logic                       busy_o;
  logic                       halt_if_o;
  logic                       halt_id_o;
  logic                       irq_ack_o;
  logic                       exc_ack_o;
  logic                       exc_kill_o;
  logic                       load_stall_o;
  logic                       jr_stall_o;
  logic                       deassert_we_o;
  logic                       misaligned_stall_o;
  core_ctrl_pkg::fw_sel_e     fw_a_o;
  core_ctrl_pkg::fw_sel_e     fw_b_o;
  core_ctrl_pkg::fw_sel_e     fw_c_o;

  row_t  rows[$];
  string group_name [5] = '{"boot", "sync traps", "interrupts", "wfi sleep", "stalls and fwd"};
  int    row_idx      = 0;
  int    group_errors = 0;
  int    total_errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    cycles       = 0;
  int    limit        = 0;

  // inputs that stay fixed for the whole run
  assign branch_taken_ex_i = 1'b0;
  assign irq_id_i          = 5'h0b;
  assign regfile_we_id_i   = 1'b0;
  assign wb_ready_i        = 1'b1;
  assign waddr_id_i        = '0;
  assign waddr_ex_i        = '0;

  core_ctrl #(
    .REG_ADDR_W (REG_ADDR_W),
    .IRQ_ID_W   (IRQ_ID_W)
  ) core_ctrl_i (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // run limit from the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run went past %0d cycles without finishing the table", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic core_ctrl_pkg::dec_info_t decode_op(op_e op);
    core_ctrl_pkg::dec_info_t d;
    d = '0;
    case (op)
      OP_ILL:   d.illegal = 1'b1;
      OP_ECALL: d.ecall   = 1'b1;
      OP_WFI:   d.wfi     = 1'b1;
      OP_JALR: begin
        d.jump_in_dec = core_ctrl_pkg::BRANCH_JALR;
        d.jump_in_id  = core_ctrl_pkg::BRANCH_JALR;
      end
      default:  d = '0;
    endcase
    return d;
  endfunction

  task automatic add_row(int grp, logic [8:0] ctl, op_e op, logic [4:0] haz, logic [8:0] mat,
                         logic [9:0] flags, logic [2:0] mux, logic [5:0] cause, logic [5:0] fw);
    row_t r;
    r = '{grp: grp[2:0], ctl: ctl, op: op, haz: haz, mat: mat,
          flags: flags, mux: mux, cause: cause, fw: fw};
    rows.push_back(r);
  endtask

  task automatic apply_row(row_t r);
    {fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i} = r.ctl[8:5];
    {irq_i, irq_req_i, m_ie_i, u_ie_i} = r.ctl[4:1];
    priv_lvl_i = r.ctl[0] ? core_ctrl_pkg::PRIV_LVL_M : core_ctrl_pkg::PRIV_LVL_U;
    dec_i      = decode_op(r.op);
    {data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i} = r.haz[4:2];
    {regfile_alu_we_fw_i, data_misaligned_i} = r.haz[1:0];
    {match_ex_i, match_wb_i, match_alu_i} = r.mat;
  endtask

  task automatic report_mismatch(string name, logic [7:0] got, logic [7:0] exp);
    $display("ERROR row %0d %s: got 0x%0h, expected 0x%0h", row_idx, name, got, exp);
    group_errors++;
    total_errors++;
  endtask

  // pc_mux only means something with pc_set, cause only with save_cause
  task automatic check_row(row_t r);
    core_ctrl_pkg::exc_pc_e exc_exp;
    // the irq vector goes with an irq ack, the exception vector with a trap
    exc_exp = r.flags[6] ? core_ctrl_pkg::EXC_PC_IRQ : core_ctrl_pkg::EXC_PC_EXCEPTION;
    if (pc_ctrl_o.pc_set !== r.flags[9])
      report_mismatch("pc_set", 8'(pc_ctrl_o.pc_set), 8'(r.flags[9]));
    if (r.flags[9] && pc_ctrl_o.pc_mux !== r.mux)
      report_mismatch("pc_mux", 8'(pc_ctrl_o.pc_mux), 8'(r.mux));
    if (r.flags[9] && r.mux == 3'd3 && pc_ctrl_o.exc_pc_mux !== exc_exp)
      report_mismatch("exc_pc_mux", 8'(pc_ctrl_o.exc_pc_mux), 8'(exc_exp));
    // both halts move together
    if (halt_id_o !== r.flags[8])
      report_mismatch("halt_id", 8'(halt_id_o), 8'(r.flags[8]));
    if (halt_if_o !== r.flags[8])
      report_mismatch("halt_if", 8'(halt_if_o), 8'(r.flags[8]));
    if (csr_ctrl_o.save_cause !== r.flags[7])
      report_mismatch("save_cause", 8'(csr_ctrl_o.save_cause), 8'(r.flags[7]));
    // every cause in the table is saved from id
    if (csr_ctrl_o.save_id !== r.flags[7])
      report_mismatch("save_id", 8'(csr_ctrl_o.save_id), 8'(r.flags[7]));
    if (r.flags[7] && csr_ctrl_o.cause !== r.cause)
      report_mismatch("cause", 8'(csr_ctrl_o.cause), 8'(r.cause));
    if (irq_ack_o !== r.flags[6])
      report_mismatch("irq_ack", 8'(irq_ack_o), 8'(r.flags[6]));
    if (exc_ack_o !== r.flags[6])
      report_mismatch("exc_ack", 8'(exc_ack_o), 8'(r.flags[6]));
    if (instr_req_o !== r.flags[5])
      report_mismatch("instr_req", 8'(instr_req_o), 8'(r.flags[5]));
    if (load_stall_o !== r.flags[4])
      report_mismatch("load_stall", 8'(load_stall_o), 8'(r.flags[4]));
    if (jr_stall_o !== r.flags[3])
      report_mismatch("jr_stall", 8'(jr_stall_o), 8'(r.flags[3]));
    if (deassert_we_o !== r.flags[2])
      report_mismatch("deassert_we", 8'(deassert_we_o), 8'(r.flags[2]));
    if (busy_o !== r.flags[1])
      report_mismatch("busy", 8'(busy_o), 8'(r.flags[1]));
    if (exc_kill_o !== r.flags[0])
      report_mismatch("exc_kill", 8'(exc_kill_o), 8'(r.flags[0]));
    // misaligned stall follows the lsu flag directly
    if (misaligned_stall_o !== r.haz[0])
      report_mismatch("misaligned_stall", 8'(misaligned_stall_o), 8'(r.haz[0]));
    if (fw_a_o !== r.fw[5:4])
      report_mismatch("fw_a", 8'(fw_a_o), 8'(r.fw[5:4]));
    if (fw_b_o !== r.fw[3:2])
      report_mismatch("fw_b", 8'(fw_b_o), 8'(r.fw[3:2]));
    if (fw_c_o !== r.fw[1:0])
      report_mismatch("fw_c", 8'(fw_c_o), 8'(r.fw[1:0]));
  endtask

  task automatic finish_group(logic [2:0] grp);
    if (group_errors == 0) begin
      $display("test %0d %s: passed", grp, group_name[grp - 1]);
      tests_passed++;
    end else begin
      $display("test %0d %s: failed with %0d mismatches", grp, group_name[grp - 1], group_errors);
      tests_failed++;
    end
    group_errors = 0;
  endtask

  ////////////////////
  // table
  ////////////////////

  // ctl   fetch_en instr_valid id_ready ex_valid irq irq_req m_ie u_ie m_level
  // haz   data_req_ex we_ex we_wb alu_we misaligned
  // mat   octal digit per stage ex wb alu, a=4 b=2 c=1
  // flags pc_set halt save_cause irq_ack instr_req load_stall jr_stall deassert_we
  //       busy exc_kill
  // mux   0 boot 1 jump 3 exception, fw  a b c with 1 = ex, 2 = wb
  task automatic build_table();
    // reset state, then one boot cycle, then first fetch until id is ready
    add_row(1, 9'b000000001, OP_NOP,   5'b00000, 9'o000, 10'b0000000110, 3'd0, 6'h00, 6'b000000);
    add_row(1, 9'b100000001, OP_NOP,   5'b00000, 9'o000, 10'b0000000110, 3'd0, 6'h00, 6'b000000);
    add_row(1, 9'b100000001, OP_NOP,   5'b00000, 9'o000, 10'b1000100110, 3'd0, 6'h00, 6'b000000);
    add_row(1, 9'b100000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100110, 3'd0, 6'h00, 6'b000000);
    add_row(1, 9'b101000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100110, 3'd0, 6'h00, 6'b000000);
    add_row(1, 9'b111000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100010, 3'd0, 6'h00, 6'b000000);
    // illegal instruction with two cycles in flush_ex
    add_row(2, 9'b111000001, OP_ILL,   5'b00000, 9'o000, 10'b0110100110, 3'd0, 6'h02, 6'b000000);
    add_row(2, 9'b111000001, OP_ILL,   5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(2, 9'b111100001, OP_ILL,   5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(2, 9'b111000001, OP_ILL,   5'b00000, 9'o000, 10'b1100100110, 3'd3, 6'h00, 6'b000000);
    // ecall from user level
    add_row(2, 9'b111000000, OP_ECALL, 5'b00000, 9'o000, 10'b0110100010, 3'd0, 6'h08, 6'b000000);
    add_row(2, 9'b111100000, OP_ECALL, 5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(2, 9'b111000000, OP_ECALL, 5'b00000, 9'o000, 10'b1100100110, 3'd3, 6'h00, 6'b000000);
    // ecall from machine level
    add_row(2, 9'b111000001, OP_ECALL, 5'b00000, 9'o000, 10'b0110100010, 3'd0, 6'h0b, 6'b000000);
    add_row(2, 9'b111000001, OP_ECALL, 5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(2, 9'b111100001, OP_ECALL, 5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(2, 9'b111000001, OP_ECALL, 5'b00000, 9'o000, 10'b1100100110, 3'd3, 6'h00, 6'b000000);
    // an enabled irq is acked with cause {1, 0x0b} two cycles on
    add_row(3, 9'b111011101, OP_NOP,   5'b00000, 9'o000, 10'b0100100010, 3'd0, 6'h00, 6'b000000);
    add_row(3, 9'b111011101, OP_NOP,   5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(3, 9'b111011101, OP_NOP,   5'b00000, 9'o000, 10'b1011100110, 3'd3, 6'h2b, 6'b000000);
    add_row(3, 9'b111000101, OP_NOP,   5'b00000, 9'o000, 10'b0000100010, 3'd0, 6'h00, 6'b000000);
    // u_ie alone must not enable at m level with m_ie clear
    add_row(3, 9'b111011011, OP_NOP,   5'b00000, 9'o000, 10'b0000100011, 3'd0, 6'h00, 6'b000000);
    add_row(3, 9'b111011011, OP_NOP,   5'b00000, 9'o000, 10'b0000100011, 3'd0, 6'h00, 6'b000000);
    add_row(3, 9'b111011011, OP_NOP,   5'b00000, 9'o000, 10'b0000100011, 3'd0, 6'h00, 6'b000000);
    // wfi flushes, sleeps with fetch off and wakes on irq
    add_row(4, 9'b111000001, OP_WFI,   5'b00000, 9'o000, 10'b0100100010, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b111100001, OP_WFI,   5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b111000001, OP_WFI,   5'b00000, 9'o000, 10'b0100100110, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b111000001, OP_WFI,   5'b00000, 9'o000, 10'b0100000100, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b110000001, OP_WFI,   5'b00000, 9'o000, 10'b0100000100, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b110000001, OP_WFI,   5'b00000, 9'o000, 10'b0100000100, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b110010001, OP_WFI,   5'b00000, 9'o000, 10'b0100000100, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b110000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100110, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b111000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100110, 3'd0, 6'h00, 6'b000000);
    add_row(4, 9'b111000001, OP_NOP,   5'b00000, 9'o000, 10'b0000100010, 3'd0, 6'h00, 6'b000000);
    // load-use, then jalr held by the alu write and released
    add_row(5, 9'b111000001, OP_NOP,   5'b11000, 9'o400, 10'b0000110110, 3'd0, 6'h00, 6'b000000);
    add_row(5, 9'b110000001, OP_JALR,  5'b00010, 9'o004, 10'b0000101110, 3'd0, 6'h00, 6'b010000);
    add_row(5, 9'b110000001, OP_JALR,  5'b00000, 9'o000, 10'b1000100010, 3'd1, 6'h00, 6'b000000);
    add_row(5, 9'b111000001, OP_JALR,  5'b00000, 9'o000, 10'b0000100010, 3'd0, 6'h00, 6'b000000);
    // ex over wb, then the misaligned override
    add_row(5, 9'b111000001, OP_NOP,   5'b00110, 9'o064, 10'b0000100010, 3'd0, 6'h00, 6'b011000);
    add_row(5, 9'b111000001, OP_NOP,   5'b00111, 9'o032, 10'b0000100010, 3'd0, 6'h00, 6'b010010);
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    row_t r;
    rst_n = 1'b0;
    apply_row('0);
    build_table();
    limit = rows.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // drive on the falling edge, check mid low phase
    for (int i = 0; i < rows.size(); i++) begin
      r       = rows[i];
      row_idx = i;
      apply_row(r);
      #(PERIOD/4);
      check_row(r);
      if (i == rows.size() - 1 || rows[i+1].grp != r.grp) begin
        finish_group(r.grp);
      end
      @(negedge clk);
    end

    $display("tests: %0d passed, %0d failed, %0d mismatches", tests_passed, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== logic/core_ctrl.sv ====
`timescale 1ns/1ps

module core_ctrl #(
  parameter int REG_ADDR_W = 6,
  parameter int IRQ_ID_W   = 5
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_enable_i,
  input  logic                       instr_valid_i,
  input  logic                       id_ready_i,
  input  logic                       ex_valid_i,
  input  logic                       branch_taken_ex_i,
  input  logic                       irq_i,
  input  logic                       irq_req_i,
  input  logic [IRQ_ID_W-1:0]        irq_id_i,
  input  logic                       m_ie_i,
  input  logic                       u_ie_i,
  input  core_ctrl_pkg::priv_lvl_e   priv_lvl_i,
  input  core_ctrl_pkg::dec_info_t   dec_i,
  input  logic                       data_req_ex_i,
  input  logic                       regfile_we_id_i,
  input  logic                       regfile_we_ex_i,
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic                       wb_ready_i,
  input  logic [REG_ADDR_W-1:0]      waddr_id_i,
  input  logic [REG_ADDR_W-1:0]      waddr_ex_i,
  input  core_ctrl_pkg::reg_match_t  match_ex_i,
  input  core_ctrl_pkg::reg_match_t  match_wb_i,
  input  core_ctrl_pkg::reg_match_t  match_alu_i,
  input  logic                       data_misaligned_i,
  output core_ctrl_pkg::pc_ctrl_t    pc_ctrl_o,
  output core_ctrl_pkg::csr_ctrl_t   csr_ctrl_o,
  output logic                       instr_req_o,
  output logic                       busy_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o,
  output logic                       irq_ack_o,
  output logic                       exc_ack_o,
  output logic                       exc_kill_o,
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o,
  output logic                       misaligned_stall_o,
  output core_ctrl_pkg::fw_sel_e     fw_a_o,
  output core_ctrl_pkg::fw_sel_e     fw_b_o,
  output core_ctrl_pkg::fw_sel_e     fw_c_o
);

  logic is_decoding;

  ctrl_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) ctrl_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .irq_i             (irq_i),
    .irq_req_i         (irq_req_i),
    .irq_id_i          (irq_id_i),
    .m_ie_i            (m_ie_i),
    .u_ie_i            (u_ie_i),
    .priv_lvl_i        (priv_lvl_i),
    .dec_i             (dec_i),
    .jr_stall_i        (jr_stall_o),
    .pc_ctrl_o         (pc_ctrl_o),
    .csr_ctrl_o        (csr_ctrl_o),
    .instr_req_o       (instr_req_o),
    .busy_o            (busy_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .is_decoding_o     (is_decoding),
    .irq_ack_o         (irq_ack_o),
    .exc_ack_o         (exc_ack_o),
    .exc_kill_o        (exc_kill_o)
  );

  hazard_unit #(
    .REG_ADDR_W (REG_ADDR_W)
  ) hazard_unit_i (
    .is_decoding_i       (is_decoding),
    .illegal_i           (dec_i.illegal),
    .jump_in_dec_i       (dec_i.jump_in_dec),
    .data_req_ex_i       (data_req_ex_i),
    .regfile_we_id_i     (regfile_we_id_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .wb_ready_i          (wb_ready_i),
    .waddr_id_i          (waddr_id_i),
    .waddr_ex_i          (waddr_ex_i),
    .match_ex_i          (match_ex_i),
    .match_wb_i          (match_wb_i),
    .match_alu_i         (match_alu_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  fwd_unit fwd_unit_i (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .data_misaligned_i   (data_misaligned_i),
    .match_wb_i          (match_wb_i),
    .match_alu_i         (match_alu_i),
    .fw_a_o              (fw_a_o),
    .fw_b_o              (fw_b_o),
    .fw_c_o              (fw_c_o)
  );

  // lsu holds id while the second access of a misaligned pair runs
  assign misaligned_stall_o = data_misaligned_i;

endmodule

// ==== logic/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

  ////////////////////
  // enumerations
  ////////////////////

  // controller fsm states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    WAIT_SLEEP,
    FIRST_FETCH,
    DECODE,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF,
    IRQ_FLUSH,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  // pc source in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_FENCEI,
    PC_MRET
  } pc_mux_e;

  // trap target, exception vs interrupt vector
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,
    EXC_PC_IRQ
  } exc_pc_e;

  // jump kind as seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE,
    BRANCH_JAL,
    BRANCH_JALR,
    BRANCH_COND
  } jump_e;

  // operand source for the id stage muxes
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } fw_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // synchronous cause codes, mcause low bits
  typedef enum logic [5:0] {
    ILLEGAL_INSN = 6'd2,
    BREAKPOINT   = 6'd3,
    ECALL_UMODE  = 6'd8,
    ECALL_MMODE  = 6'd11
  } exc_cause_e;

  ////////////////////
  // bundles
  ////////////////////

  // decoder flags for the instruction in id
  typedef struct packed {
    logic  illegal;
    logic  ecall;
    logic  ebrk;
    logic  mret;
    logic  fencei;
    logic  wfi;
    jump_e jump_in_dec;
    jump_e jump_in_id;
  } dec_info_t;

  // one stage's destination compared against the three sources
  typedef struct packed {
    logic is_a;
    logic is_b;
    logic is_c;
  } reg_match_t;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    exc_pc_e exc_pc_mux;
  } pc_ctrl_t;

  // cause[5] marks an interrupt, low bits hold irq id or exc_cause_e
  typedef struct packed {
    logic       save_if;
    logic       save_id;
    logic       save_cause;
    logic       restore_mret;
    logic [5:0] cause;
  } csr_ctrl_t;

endpackage

// ==== logic/ctrl_fsm.sv ====
`timescale 1ns/1ps

module ctrl_fsm #(
  parameter int IRQ_ID_W = 5
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  input  logic                      instr_valid_i,
  input  logic                      id_ready_i,
  input  logic                      ex_valid_i,
  input  logic                      branch_taken_ex_i,
  input  logic                      irq_i,
  input  logic                      irq_req_i,
  input  logic [IRQ_ID_W-1:0]       irq_id_i,
  input  logic                      m_ie_i,
  input  logic                      u_ie_i,
  input  core_ctrl_pkg::priv_lvl_e  priv_lvl_i,
  input  core_ctrl_pkg::dec_info_t  dec_i,
  input  logic                      jr_stall_i,
  output core_ctrl_pkg::pc_ctrl_t   pc_ctrl_o,
  output core_ctrl_pkg::csr_ctrl_t  csr_ctrl_o,
  output logic                      instr_req_o,
  output logic                      busy_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      is_decoding_o,
  output logic                      irq_ack_o,
  output logic                      exc_ack_o,
  output logic                      exc_kill_o
);

  core_ctrl_pkg::ctrl_state_e state_q, state_d;
  logic jump_done_q, jump_done_d;
  logic irq_enable;
  logic jump_in_dec;
  logic sync_trap;

  // interrupts only honoured when the enable of the current level is set
  assign irq_enable = (m_ie_i && (priv_lvl_i == core_ctrl_pkg::PRIV_LVL_M)) ||
                      (u_ie_i && (priv_lvl_i == core_ctrl_pkg::PRIV_LVL_U));

  // jal and jalr resolve in id, conditional branches in ex
  assign jump_in_dec = (dec_i.jump_in_dec == core_ctrl_pkg::BRANCH_JAL) ||
                       (dec_i.jump_in_dec == core_ctrl_pkg::BRANCH_JALR);

  // held in id through both flush states
  assign sync_trap = dec_i.illegal || dec_i.ecall || dec_i.ebrk;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    busy_o        = 1'b1;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    is_decoding_o = 1'b0;
    irq_ack_o     = 1'b0;
    exc_ack_o     = 1'b0;
    exc_kill_o    = 1'b0;
    csr_ctrl_o    = '0;
    pc_ctrl_o     = '{pc_set: 1'b0,
                      pc_mux: core_ctrl_pkg::PC_BOOT,
                      exc_pc_mux: core_ctrl_pkg::EXC_PC_IRQ};

    unique case (state_q)
      core_ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = core_ctrl_pkg::BOOT_SET;
        end
      end

      // load boot address into the fetch pc
      core_ctrl_pkg::BOOT_SET: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_BOOT;
        state_d          = core_ctrl_pkg::FIRST_FETCH;
      end

      core_ctrl_pkg::WAIT_SLEEP, core_ctrl_pkg::SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (state_q == core_ctrl_pkg::WAIT_SLEEP) begin
          state_d = core_ctrl_pkg::SLEEP;
        end else if (irq_i) begin
          // wake up into the pipeline left empty by the wfi flush
          state_d = core_ctrl_pkg::FIRST_FETCH;
        end
      end

      core_ctrl_pkg::FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = core_ctrl_pkg::DECODE;
        end
        // nothing is in flight yet so the irq is taken from if
        if (irq_req_i && irq_enable) begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = core_ctrl_pkg::IRQ_TAKEN_IF;
        end
      end

      core_ctrl_pkg::DECODE: begin
        if (branch_taken_ex_i) begin
          // ex redirect wins over whatever sits in id
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_BRANCH;
        end else if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          if (irq_req_i && irq_enable) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = core_ctrl_pkg::IRQ_FLUSH;
          end else begin
            exc_kill_o = irq_req_i;
            if (sync_trap) begin
              halt_if_o             = 1'b1;
              halt_id_o             = 1'b1;
              csr_ctrl_o.save_id    = 1'b1;
              csr_ctrl_o.save_cause = 1'b1;
              state_d               = core_ctrl_pkg::FLUSH_EX;
              if (dec_i.illegal) begin
                csr_ctrl_o.cause = core_ctrl_pkg::ILLEGAL_INSN;
              end else if (dec_i.ebrk) begin
                csr_ctrl_o.cause = core_ctrl_pkg::BREAKPOINT;
              end else if (priv_lvl_i == core_ctrl_pkg::PRIV_LVL_U) begin
                csr_ctrl_o.cause = core_ctrl_pkg::ECALL_UMODE;
              end else begin
                csr_ctrl_o.cause = core_ctrl_pkg::ECALL_MMODE;
              end
            end else if (jump_in_dec) begin
              pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_JUMP;
              // wait out a jr hazard, and jump only once per instruction
              if (!jr_stall_i && !jump_done_q) begin
                pc_ctrl_o.pc_set = 1'b1;
                jump_done_d      = 1'b1;
              end
            end else if (dec_i.mret || dec_i.fencei || dec_i.wfi) begin
              halt_if_o               = 1'b1;
              halt_id_o               = 1'b1;
              csr_ctrl_o.restore_mret = dec_i.mret;
              state_d                 = core_ctrl_pkg::FLUSH_EX;
            end
          end
        end
      end

      // drain ex with its variable latency
      core_ctrl_pkg::FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = core_ctrl_pkg::FLUSH_WB;
        end
      end

      core_ctrl_pkg::FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (sync_trap) begin
          pc_ctrl_o.pc_set     = 1'b1;
          pc_ctrl_o.pc_mux     = core_ctrl_pkg::PC_EXCEPTION;
          pc_ctrl_o.exc_pc_mux = core_ctrl_pkg::EXC_PC_EXCEPTION;
        end else if (dec_i.mret) begin
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_MRET;
        end else if (dec_i.fencei) begin
          // refetch from the next instruction
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_FENCEI;
        end
        state_d = dec_i.wfi ? core_ctrl_pkg::WAIT_SLEEP : core_ctrl_pkg::DECODE;
      end

      core_ctrl_pkg::IRQ_FLUSH: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        // the request or the enable may have dropped since decode
        if (irq_i && irq_enable) begin
          state_d = core_ctrl_pkg::IRQ_TAKEN_ID;
        end else begin
          exc_kill_o = 1'b1;
          state_d    = core_ctrl_pkg::DECODE;
        end
      end

      core_ctrl_pkg::IRQ_TAKEN_ID, core_ctrl_pkg::IRQ_TAKEN_IF: begin
        pc_ctrl_o.pc_set      = 1'b1;
        pc_ctrl_o.pc_mux      = core_ctrl_pkg::PC_EXCEPTION;
        pc_ctrl_o.exc_pc_mux  = core_ctrl_pkg::EXC_PC_IRQ;
        csr_ctrl_o.cause      = {1'b1, irq_id_i};
        csr_ctrl_o.save_cause = 1'b1;
        // epc comes from id or from if depending on where it was taken
        csr_ctrl_o.save_id    = (state_q == core_ctrl_pkg::IRQ_TAKEN_ID);
        csr_ctrl_o.save_if    = (state_q == core_ctrl_pkg::IRQ_TAKEN_IF);
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
        state_d               = core_ctrl_pkg::DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = core_ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= core_ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // released once the jump leaves id
      jump_done_q <= jump_done_d && !id_ready_i;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // no branch prediction, so a taken branch is never followed by another
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("back-to-back taken branches");

  // an irq is only taken after the irq flush or straight from first fetch
  assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |->
      ($past(state_q) inside {core_ctrl_pkg::IRQ_FLUSH, core_ctrl_pkg::FIRST_FETCH}))
    else $error("irq acknowledged without passing irq flush or first fetch");

endmodule

// ==== logic/fwd_unit.sv ====
`timescale 1ns/1ps

module fwd_unit (
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic                       data_misaligned_i,
  input  core_ctrl_pkg::reg_match_t  match_wb_i,
  input  core_ctrl_pkg::reg_match_t  match_alu_i,
  output core_ctrl_pkg::fw_sel_e     fw_a_o,
  output core_ctrl_pkg::fw_sel_e     fw_b_o,
  output core_ctrl_pkg::fw_sel_e     fw_c_o
);

  always_comb begin
    fw_a_o = core_ctrl_pkg::SEL_REGFILE;
    fw_b_o = core_ctrl_pkg::SEL_REGFILE;
    fw_c_o = core_ctrl_pkg::SEL_REGFILE;

    // wb -> id
    if (regfile_we_wb_i) begin
      if (match_wb_i.is_a) fw_a_o = core_ctrl_pkg::SEL_FW_WB;
      if (match_wb_i.is_b) fw_b_o = core_ctrl_pkg::SEL_FW_WB;
      if (match_wb_i.is_c) fw_c_o = core_ctrl_pkg::SEL_FW_WB;
    end

    // ex -> id, younger result so it wins over wb
    if (regfile_alu_we_fw_i) begin
      if (match_alu_i.is_a) fw_a_o = core_ctrl_pkg::SEL_FW_EX;
      if (match_alu_i.is_b) fw_b_o = core_ctrl_pkg::SEL_FW_EX;
      if (match_alu_i.is_c) fw_c_o = core_ctrl_pkg::SEL_FW_EX;
    end

    // second half of a misaligned access reuses the ex address
    if (data_misaligned_i) begin
      fw_a_o = core_ctrl_pkg::SEL_FW_EX;
      fw_b_o = core_ctrl_pkg::SEL_REGFILE;
    end
  end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit #(
  parameter int REG_ADDR_W = 6
) (
  input  logic                       is_decoding_i,
  input  logic                       illegal_i,
  input  core_ctrl_pkg::jump_e       jump_in_dec_i,
  input  logic                       data_req_ex_i,
  input  logic                       regfile_we_id_i,
  input  logic                       regfile_we_ex_i,
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic                       wb_ready_i,
  input  logic [REG_ADDR_W-1:0]      waddr_id_i,
  input  logic [REG_ADDR_W-1:0]      waddr_ex_i,
  input  core_ctrl_pkg::reg_match_t  match_ex_i,
  input  core_ctrl_pkg::reg_match_t  match_wb_i,
  input  core_ctrl_pkg::reg_match_t  match_alu_i,
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o
);

  logic load_pending;
  logic load_dep;

  // load in ex, or a write stuck in wb
  assign load_pending = (data_req_ex_i && regfile_we_ex_i) || (!wb_ready_i && regfile_we_wb_i);

  // any source read, or a waw on the decoded destination
  assign load_dep = match_ex_i.is_a || match_ex_i.is_b || match_ex_i.is_c ||
                    (is_decoding_i && regfile_we_id_i && (waddr_ex_i == waddr_id_i));

  assign load_stall_o = load_pending && load_dep;

  // jalr target needs rs1 straight from the regfile, no forwarding to the pc
  assign jr_stall_o = (jump_in_dec_i == core_ctrl_pkg::BRANCH_JALR) &&
                      ((regfile_we_wb_i && match_wb_i.is_a) ||
                       (regfile_we_ex_i && match_ex_i.is_a) ||
                       (regfile_alu_we_fw_i && match_alu_i.is_a));

  // a stalled instruction must never commit its write
  assign deassert_we_o = load_stall_o || jr_stall_o || illegal_i || !is_decoding_i;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module core_ctrl_tb -o core_ctrl_sim

out=$(./obj_dir/core_ctrl_sim)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -q "^Simulation passed$"
